// ==== Makefile ====
TOP := sqz_io_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

// ==== hdl/block_dma.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module block_dma (
	input  logic                    okClk,
	input  logic                    arst_n,
	input  sqz_io_pkg::dma_ctrl_t   dma_ctrl,
	input  sqz_io_pkg::host_word_t  in_word,
	input  logic                    in_empty,
	input  sqz_io_pkg::fifo_count_t out_count,
	output logic                    in_pop,
	output logic                    out_push,
	output sqz_io_pkg::host_word_t  out_data,
	output logic                    done,
	output logic                    busy
);
	import sqz_io_pkg::*;

	localparam int FIFO_DEPTH = `SQZ_FIFO_DEPTH;
	localparam int STORE_LAST = `SQZ_STORE_WORDS - 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITE,
		S_READ
	} state_t;

	state_t      state;
	store_addr_t addr;
	op_num_t     remaining;  // words left to store or to issue
	logic [1:0]  rd_vld;     // [0] word at store output, [1] word in out_data
	logic [10:0] out_level;  // pipe-out words plus reads in flight
	logic        wr_fire;
	logic        rd_fire;
	logic        finish;
	host_word_t  rd_data;

	assign out_level = {1'b0, out_count} + 11'(rd_vld[0]) + 11'(rd_vld[1]);
	assign wr_fire   = (state == S_WRITE) && (remaining != '0) && !in_empty;
	assign rd_fire   = (state == S_READ) && (remaining != '0) && (out_level < 11'(FIFO_DEPTH));
	assign in_pop    = wr_fire;
	assign out_push  = rd_vld[1];
	assign busy      = (state != S_IDLE);

	always_comb begin
		case (state)
			S_WRITE: finish = (remaining == '0) || (wr_fire && remaining == op_num_t'(1));
			S_READ:  finish = (remaining == '0) && !rd_vld[0]; // last word pushed this cycle
			default: finish = 1'b0;
		endcase
	end

	word_store u_store (
		.okClk   (okClk),
		.wr_en   (wr_fire),
		.wr_addr (addr),
		.wr_data (in_word),
		.rd_addr (addr),
		.rd_data (rd_data)
	);

	//------------------------------
	// phase control
	//------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= S_IDLE;
			addr      <= '0;
			remaining <= '0;
			rd_vld    <= '0;
			done      <= 1'b0;
		end else begin
			done   <= 1'b0;
			rd_vld <= {rd_vld[0], rd_fire};
			case (state)
				S_IDLE: begin
					// hold off while done is out, the enable clears next cycle
					if (!done && (dma_ctrl.writes_en || dma_ctrl.reads_en)) begin
						state     <= dma_ctrl.writes_en ? S_WRITE : S_READ;
						addr      <= dma_ctrl.start_addr;
						remaining <= dma_ctrl.op_num;
					end
				end
				default: begin
					if (wr_fire || rd_fire) begin
						addr      <= (addr == store_addr_t'(STORE_LAST)) ? '0 : addr + 1'b1;
						remaining <= remaining - 1'b1;
					end
					if (finish) begin
						state <= S_IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (rd_vld[0]) begin
			out_data <= rd_data;   // second read stage
		end
	end

endmodule

// ==== hdl/block_fifo.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module block_fifo #(
	parameter type payload_t = sqz_io_pkg::host_word_t
) (
	input  logic                    okClk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    push,
	input  payload_t                push_data,
	input  logic                    pop,
	output payload_t                pop_data,
	output logic                    empty,
	output logic                    full,
	output sqz_io_pkg::fifo_count_t count
);
	import sqz_io_pkg::*;

	localparam int DEPTH = `SQZ_FIFO_DEPTH;

	payload_t    mem [DEPTH];
	fifo_count_t wr_ptr;
	fifo_count_t rd_ptr;
	logic        do_push;
	logic        do_pop;

	function automatic fifo_count_t next_ptr(input fifo_count_t ptr);
		return (ptr == fifo_count_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign full     = (count == fifo_count_t'(DEPTH));
	assign do_push  = push && !full;     // overflow push dropped
	assign do_pop   = pop && !empty;     // underflow pop dropped
	assign pop_data = mem[rd_ptr];       // show-ahead head word

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + fifo_count_t'(do_push) - fifo_count_t'(do_pop);
		end
	end

endmodule

// ==== hdl/host_ctrl_regs.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module host_ctrl_regs (
	input  logic                   okClk,
	input  logic                   arst_n,
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	input  logic                   done,
	input  sqz_io_pkg::io_status_t status,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output sqz_io_pkg::dma_ctrl_t  dma_ctrl,
	output logic                   fifo_flush
);
	import sqz_io_pkg::*;

	logic access;     // APB access phase
	logic wr_access;
	logic mapped;

	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign pready    = 1'b1;             // no wait states
	assign pslverr   = access && !mapped;

	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			`SQZ_REG_CTRL:   prdata = {30'd0, dma_ctrl.writes_en, dma_ctrl.reads_en};
			`SQZ_REG_ADDR:   prdata = 32'(dma_ctrl.start_addr);
			`SQZ_REG_NUM:    prdata = 32'(dma_ctrl.op_num);
			`SQZ_REG_STATUS: prdata = 32'(status);
			default:         mapped = 1'b0;
		endcase
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			dma_ctrl   <= '0;
			fifo_flush <= 1'b0;
		end else begin
			fifo_flush <= 1'b0;
			if (done) begin
				// write phase has priority, so it is the one that ran
				if (dma_ctrl.writes_en) begin
					dma_ctrl.writes_en <= 1'b0;
				end else begin
					dma_ctrl.reads_en <= 1'b0;
				end
			end
			if (wr_access) begin
				case (paddr)
					`SQZ_REG_CTRL: begin
						dma_ctrl.reads_en  <= pwdata[0];
						dma_ctrl.writes_en <= pwdata[1];
						fifo_flush         <= pwdata[2];   // one cycle pulse
					end
					`SQZ_REG_ADDR: dma_ctrl.start_addr <= store_addr_t'(pwdata);
					`SQZ_REG_NUM:  dma_ctrl.op_num     <= op_num_t'(pwdata);
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hdl/pipe_in_port.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module pipe_in_port (
	input  logic                   okClk,
	input  logic                   arst_n,
	input  logic                   flush,
	input  logic                   pipe_in_write,
	input  sqz_io_pkg::host_word_t pipe_in_data,
	input  logic                   in_pop,
	output logic                   pipe_in_ready,
	output sqz_io_pkg::host_word_t in_word,
	output logic                   in_empty,
	output logic                   in_full
);
	import sqz_io_pkg::*;

	// room for one more whole block, with headroom for the lagging count
	localparam int READY_LIMIT = `SQZ_FIFO_DEPTH - `SQZ_BUFFER_HEADROOM - `SQZ_BLOCK_SIZE;

	fifo_count_t in_count;

	block_fifo #(.payload_t(host_word_t)) u_in_fifo (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.flush     (flush),
		.push      (pipe_in_write),
		.push_data (pipe_in_data),
		.pop       (in_pop),
		.pop_data  (in_word),
		.empty     (in_empty),
		.full      (in_full),
		.count     (in_count)
	);

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_in_ready <= 1'b0;
		end else begin
			pipe_in_ready <= flush || (in_count <= fifo_count_t'(READY_LIMIT)); // flush empties it
		end
	end

endmodule

// ==== hdl/pipe_out_port.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module pipe_out_port (
	input  logic                    okClk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    out_push,
	input  sqz_io_pkg::host_word_t  out_data,
	input  logic                    pipe_out_read,
	output logic                    pipe_out_ready,
	output sqz_io_pkg::out_word_t   pipe_out_data,
	output sqz_io_pkg::fifo_count_t out_count,
	output logic                    out_empty,
	output logic                    out_full
);
	import sqz_io_pkg::*;

	localparam int BLOCK = `SQZ_BLOCK_SIZE;
	localparam int IDX_W = $clog2(BLOCK);

	logic [IDX_W-1:0] word_idx;  // position inside the current block
	logic             accepted;
	out_word_t        push_word;

	assign accepted            = out_push && !out_full;
	assign push_word.data      = out_data;
	assign push_word.block_end = (word_idx == IDX_W'(BLOCK - 1));

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			word_idx       <= '0;
			pipe_out_ready <= 1'b0;
		end else begin
			if (flush) begin
				word_idx <= '0;
			end else if (accepted) begin
				word_idx <= push_word.block_end ? '0 : word_idx + 1'b1;
			end
			pipe_out_ready <= !flush && (out_count >= fifo_count_t'(BLOCK)); // a whole block waits
		end
	end

	block_fifo #(.payload_t(out_word_t)) u_out_fifo (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.flush     (flush),
		.push      (out_push),
		.push_data (push_word),
		.pop       (pipe_out_read),
		.pop_data  (pipe_out_data),
		.empty     (out_empty),
		.full      (out_full),
		.count     (out_count)
	);

endmodule

// ==== hdl/sqz_io_pkg.sv ====
package sqz_io_pkg;

	// ------------------------------
	// scalar types
	// ------------------------------
	typedef logic [31:0] host_word_t;   // one pipe word
	typedef logic [9:0]  store_addr_t;  // word address into the store
	typedef logic [9:0]  fifo_count_t;  // fifo occupancy, up to 1023
	typedef logic [15:0] op_num_t;      // words per transfer

	// pipe-out payload, block_end marks the last word of a host block
	typedef struct packed {
		host_word_t data;
		logic       block_end;
	} out_word_t;

	// DMA programming from the register block
	typedef struct packed {
		logic        reads_en;    // store to pipe-out
		logic        writes_en;   // pipe-in to store, wins over reads_en
		store_addr_t start_addr;
		op_num_t     op_num;
	} dma_ctrl_t;

	// STATUS word, dma_busy lands in bit 0
	typedef struct packed {
		logic in_full;
		logic in_empty;
		logic out_full;
		logic out_empty;
		logic dma_busy;
	} io_status_t;

endpackage

// ==== hdl/sqz_io_settings.svh ====
`ifndef SQZ_IO_SETTINGS_SVH
`define SQZ_IO_SETTINGS_SVH

// ------------------------------
// host block framing
// ------------------------------
`define SQZ_BLOCK_SIZE      128    // 512 bytes per host block
`define SQZ_FIFO_DEPTH      1023   // usable entries in each pipe FIFO
`define SQZ_BUFFER_HEADROOM 20     // slack for the count update latency

// ------------------------------
// on-chip word store
// ------------------------------
`define SQZ_STORE_WORDS     1024

// ------------------------------
// APB register offsets
// ------------------------------
`define SQZ_REG_CTRL        8'h00  // bit0 reads_en, bit1 writes_en, bit2 fifo reset
`define SQZ_REG_ADDR        8'h04  // store start address
`define SQZ_REG_NUM         8'h08  // transfer length in words
`define SQZ_REG_STATUS      8'h0C  // fifo and dma flags, read only
`endif

// ==== hdl/sqz_io_top.sv ====
`timescale 1ns/100ps

module sqz_io_top (
	input  logic                   okClk,
	input  logic                   arst_n,
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   pipe_in_write,
	input  sqz_io_pkg::host_word_t pipe_in_data,
	output logic                   pipe_in_ready,
	input  logic                   pipe_out_read,
	output logic                   pipe_out_ready,
	output sqz_io_pkg::out_word_t  pipe_out_data
);
	import sqz_io_pkg::*;

	// ------------------------------
	// internal links
	// ------------------------------
	dma_ctrl_t   dma_ctrl;
	io_status_t  status;
	host_word_t  in_word;
	host_word_t  out_data;
	fifo_count_t out_count;
	logic        fifo_flush;
	logic        done;
	logic        busy;
	logic        in_pop;
	logic        in_empty;
	logic        in_full;
	logic        out_push;
	logic        out_empty;
	logic        out_full;

	assign status = '{in_full: in_full, in_empty: in_empty, out_full: out_full,
	                  out_empty: out_empty, dma_busy: busy};  // led monitor word

	host_ctrl_regs u_regs (.okClk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
		.done, .status, .prdata, .pready, .pslverr, .dma_ctrl, .fifo_flush);

	pipe_in_port u_pipe_in (.okClk, .arst_n, .flush(fifo_flush), .pipe_in_write,
		.pipe_in_data, .in_pop, .pipe_in_ready, .in_word, .in_empty, .in_full);

	block_dma u_dma (.okClk, .arst_n, .dma_ctrl, .in_word, .in_empty, .out_count,
		.in_pop, .out_push, .out_data, .done, .busy);

	pipe_out_port u_pipe_out (.okClk, .arst_n, .flush(fifo_flush), .out_push, .out_data,
		.pipe_out_read, .pipe_out_ready, .pipe_out_data, .out_count, .out_empty, .out_full);

endmodule

// ==== hdl/word_store.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module word_store (
	input  logic                    okClk,
	input  logic                    wr_en,
	input  sqz_io_pkg::store_addr_t wr_addr,
	input  sqz_io_pkg::host_word_t  wr_data,
	input  sqz_io_pkg::store_addr_t rd_addr,
	output sqz_io_pkg::host_word_t  rd_data
);
	import sqz_io_pkg::*;

	host_word_t mem [`SQZ_STORE_WORDS];

	// ------------------------------
	// simple dual port, registered read
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];   // data one cycle after the address
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/sqz_io_pkg.sv
hdl/block_fifo.sv
hdl/pipe_in_port.sv
hdl/pipe_out_port.sv
hdl/word_store.sv
hdl/block_dma.sv
hdl/host_ctrl_regs.sv
hdl/sqz_io_top.sv
tests/sqz_io_asserts.sv
tests/sqz_io_tb.sv

// ==== tests/sqz_io_asserts.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module sqz_io_asserts (
	input logic                    okClk,
	input logic                    arst_n,
	input logic                    pready,
	input logic                    pipe_in_ready,
	input sqz_io_pkg::fifo_count_t in_count,
	input logic                    pipe_out_ready,
	input logic                    out_empty,
	input logic                    done
);
	import sqz_io_pkg::*;

	localparam int READY_LIMIT = `SQZ_FIFO_DEPTH - `SQZ_BUFFER_HEADROOM - `SQZ_BLOCK_SIZE;

	int unsigned fail_count = 0;   // failed checks of this module

	// ------------------------------
	// APB and host pipe flags
	// ------------------------------
	pready_high: assert property (@(posedge okClk) disable iff (!arst_n) pready)
		else begin
			$error("pready low, APB slave inserted a wait state");
			fail_count++;
		end

	// ready lags the count by one cycle
	in_throttle: assert property (@(posedge okClk) disable iff (!arst_n)
		(!pipe_in_ready && $past(arst_n)) |-> ($past(in_count) > fifo_count_t'(READY_LIMIT)))
		else begin
			$error("pipe_in_ready low while the pipe-in FIFO had room for a block");
			fail_count++;
		end

	out_ready_data: assert property (@(posedge okClk) disable iff (!arst_n)
		pipe_out_ready |-> !out_empty)
		else begin
			$error("pipe_out_ready high with an empty pipe-out FIFO");
			fail_count++;
		end

	done_single: assert property (@(posedge okClk) disable iff (!arst_n) done |=> !done)
		else begin
			$error("DMA done held high for two cycles");
			fail_count++;
		end

endmodule

// ==== tests/sqz_io_tb.sv ====
`timescale 1ns/100ps
`include "sqz_io_settings.svh"

module sqz_io_tb;
	import sqz_io_pkg::*;

	localparam int BLOCK       = `SQZ_BLOCK_SIZE;
	localparam int READY_LIMIT = `SQZ_FIFO_DEPTH - `SQZ_BUFFER_HEADROOM - `SQZ_BLOCK_SIZE;
	localparam int WAIT_LIMIT  = 5000;  // cycles per handshake wait
	localparam int POLL_LIMIT  = 500;   // CTRL reads per poll
	localparam io_status_t IDLE_STATUS = '{in_full: 1'b0, in_empty: 1'b1, out_full: 1'b0,
		out_empty: 1'b1, dma_busy: 1'b0};

	logic        okClk;
	logic        arst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        pipe_in_write;
	host_word_t  pipe_in_data;
	logic        pipe_in_ready;
	logic        pipe_out_read;
	logic        pipe_out_ready;
	out_word_t   pipe_out_data;

	host_word_t  sent_q [$];  // words on their way through the DUT, oldest first
	integer      seed;
	int          errors;
	int          timeouts;
	int          blocks;
	logic [31:0] rd;
	logic        err;
	io_status_t  status_rd;

	sqz_io_top uut (.okClk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .pipe_in_write, .pipe_in_data, .pipe_in_ready, .pipe_out_read,
		.pipe_out_ready, .pipe_out_data);

	bind sqz_io_top sqz_io_asserts u_asserts (.okClk, .arst_n, .pready, .pipe_in_ready,
		.in_count(u_pipe_in.in_count), .pipe_out_ready, .out_empty, .done);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// APB and host pipe drivers
	// ------------------------------
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		@(posedge okClk);
		psel    <= 1'b1;   // setup cycle
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge okClk);
		penable <= 1'b1;   // access cycle
		@(negedge okClk);
		rdata  = prdata;
		slverr = pslverr;
		@(posedge okClk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused_rd;
		logic        slverr;
		apb_xfer(1'b1, addr, wdata, unused_rd, slverr);
		check_value("pslverr on write", 32'(slverr), 32'd0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
		logic slverr;
		apb_xfer(1'b0, addr, '0, rdata, slverr);
		check_value("pslverr on read", 32'(slverr), 32'd0);
	endtask

	task automatic wait_ready(input logic out_side);
		int cnt;
		if (timeouts != 0) return;
		cnt = 0;
		@(negedge okClk);
		while (!(out_side ? pipe_out_ready : pipe_in_ready) && cnt < WAIT_LIMIT) begin
			@(negedge okClk);
			cnt++;
		end
		if (!(out_side ? pipe_out_ready : pipe_in_ready)) begin
			timeouts++;
			$display("timeout: %s never went high", out_side ? "pipe_out_ready" : "pipe_in_ready");
		end
	endtask

	task automatic wait_ctrl_clear(input logic [31:0] mask);
		logic [31:0] ctrl;
		int          cnt;
		if (timeouts != 0) return;
		cnt = 0;
		apb_read(`SQZ_REG_CTRL, ctrl);
		while ((ctrl & mask) != 0 && cnt < POLL_LIMIT) begin
			apb_read(`SQZ_REG_CTRL, ctrl);
			cnt++;
		end
		if ((ctrl & mask) != 0) begin
			timeouts++;
			$display("timeout: DMA never finished, CTRL still %h", ctrl);
		end
	endtask

	task automatic push_block();
		host_word_t w;
		wait_ready(1'b0);
		if (timeouts != 0) return;
		for (int i = 0; i < BLOCK; i++) begin
			w = $random(seed);
			sent_q.push_back(w);
			@(posedge okClk);
			pipe_in_write <= 1'b1;
			pipe_in_data  <= w;
		end
		@(posedge okClk);
		pipe_in_write <= 1'b0;
	endtask

	task automatic pop_block();
		host_word_t exp;
		wait_ready(1'b1);
		if (timeouts != 0) return;
		for (int i = 0; i < BLOCK; i++) begin
			@(posedge okClk);
			pipe_out_read <= 1'b1;
			@(negedge okClk);   // head word is popped at the next rising edge
			if (sent_q.size() > 0) begin
				exp = sent_q.pop_front();
			end else begin
				exp = 'x;
			end
			check_value("pipe_out data", pipe_out_data.data, exp);
			check_value("block_end", 32'(pipe_out_data.block_end), 32'(i == BLOCK - 1));
		end
		@(posedge okClk);
		pipe_out_read <= 1'b0;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		seed     = 32'h8e39_b677;
		errors   = 0;
		timeouts = 0;
		arst_n        <= 1'b0;
		paddr         <= '0;
		psel          <= 1'b0;
		penable       <= 1'b0;
		pwrite        <= 1'b0;
		pwdata        <= '0;
		pipe_in_write <= 1'b0;
		pipe_in_data  <= '0;
		pipe_out_read <= 1'b0;
		repeat (15) @(posedge okClk);
		@(negedge okClk);
		check_value("pipe_in_ready in reset", 32'(pipe_in_ready), 32'd0);
		check_value("pipe_out_ready in reset", 32'(pipe_out_ready), 32'd0);
		@(posedge okClk);
		arst_n <= 1'b1;
		apb_read(`SQZ_REG_STATUS, rd);
		check_value("STATUS after reset", rd, 32'(IDLE_STATUS));

		apb_write(`SQZ_REG_ADDR, 32'd40);
		apb_write(`SQZ_REG_NUM, 32'd256);
		apb_read(`SQZ_REG_ADDR, rd);
		check_value("ADDR readback", rd, 32'd40);
		apb_read(`SQZ_REG_NUM, rd);
		check_value("NUM readback", rd, 32'd256);
		apb_xfer(1'b0, 8'h10, '0, rd, err);
		check_value("pslverr at 0x10", 32'(err), 32'd1);

		// loopback of two blocks through the store at address 40
		push_block();
		push_block();
		apb_write(`SQZ_REG_CTRL, 32'h2);
		wait_ctrl_clear(32'h2);
		apb_write(`SQZ_REG_CTRL, 32'h1);
		pop_block();
		pop_block();
		wait_ctrl_clear(32'h1);
		check_value("words never returned", 32'(sent_q.size()), 32'd0);
		apb_read(`SQZ_REG_STATUS, rd);
		check_value("STATUS after loopback", rd, 32'(IDLE_STATUS));

		// fill the idle pipe-in FIFO until the throttle kicks in
		blocks = 0;
		@(negedge okClk);
		while (pipe_in_ready && blocks < `SQZ_FIFO_DEPTH / BLOCK && timeouts == 0) begin
			push_block();
			blocks++;
			repeat (3) @(negedge okClk);   // count and ready lag the last push
		end
		check_value("blocks before throttle", 32'(blocks), 32'(READY_LIMIT / BLOCK + 1));
		check_value("pipe_in_ready when full", 32'(pipe_in_ready), 32'd0);
		apb_read(`SQZ_REG_STATUS, rd);
		status_rd = io_status_t'(rd[4:0]);
		check_value("STATUS in_empty when full", 32'(status_rd.in_empty), 32'd0);

		apb_write(`SQZ_REG_CTRL, 32'h1);   // refill the pipe-out FIFO from the store
		wait_ctrl_clear(32'h1);
		apb_write(`SQZ_REG_CTRL, 32'h4);
		sent_q.delete();
		wait_ready(1'b0);
		apb_read(`SQZ_REG_STATUS, rd);
		check_value("STATUS after flush", rd, 32'(IDLE_STATUS));

		$display("errors: %0d data, %0d assertion, %0d timeout", errors,
			uut.u_asserts.fail_count, timeouts);
		if (errors == 0 && uut.u_asserts.fail_count == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
